// File: verilog/text_pkg.sv
`default_nettype none

package text_pkg;

   localparam int VRAM_ADDR_W = 12;       // 4 KiB of video memory

   typedef logic [VRAM_ADDR_W-1:0] vram_addr_t;
   typedef logic [7:0]             char_code_t;
   typedef logic [3:0]             color_idx_t;
   typedef logic [15:0]            rgb_t;   // RGB565
   typedef logic [3:0]             reg_off_t;

   // CPU register map
   localparam reg_off_t REG_TEXT_LO  = 4'd0;
   localparam reg_off_t REG_TEXT_HI  = 4'd1;
   localparam reg_off_t REG_ATTR_LO  = 4'd2;
   localparam reg_off_t REG_ATTR_HI  = 4'd3;
   localparam reg_off_t REG_CHARSET  = 4'd4;   // font base in 256 byte pages
   localparam reg_off_t REG_PAL_IDX  = 4'd5;
   localparam reg_off_t REG_PAL_DATA = 4'd6;   // low byte, then high byte
   localparam reg_off_t REG_VADDR_LO = 4'd8;
   localparam reg_off_t REG_VADDR_HI = 4'd9;
   localparam reg_off_t REG_VDATA    = 4'd10;

   typedef struct packed {
      logic [7:0] bitmap;   // one font row, msb is leftmost pixel
      color_idx_t fg;
      color_idx_t bg;
   } glyph_slice_t;

   typedef struct packed {
      logic       en;
      color_idx_t idx;
      rgb_t       color;
   } pal_wr_t;

   typedef struct packed {
      logic       en;
      vram_addr_t addr;
      char_code_t data;
   } vram_wr_t;

   typedef struct packed {
      vram_addr_t text_base;
      vram_addr_t attr_base;
      logic [7:0] charset;
   } disp_cfg_t;

   typedef enum logic [2:0] {IDLE, TEXT, ATTR, FONT, SEND} fetch_state_t;

endpackage

`default_nettype wire

// File: verilog/video_ram.sv
`timescale 1ns/10ps
`default_nettype none

module video_ram (
   input  wire logic                sys_clk,
   input  wire text_pkg::vram_wr_t  wr,
   input  wire text_pkg::vram_addr_t rd_addr,
   output logic [7:0]               rd_data
);

   localparam int DEPTH = 2 ** text_pkg::VRAM_ADDR_W;

   logic [7:0] mem [DEPTH];

   // cpu side, write only
   always_ff @(posedge sys_clk) begin
      if (wr.en) begin
         mem[wr.addr] <= wr.data;
      end
   end

   // engine side, one cycle read latency
   always_ff @(posedge sys_clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// File: verilog/cpu_regs.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_regs (
   input  wire logic               sys_clk,
   input  wire logic               rst,
   input  wire logic               cpu_wr,
   input  wire logic               cpu_rd,
   input  wire text_pkg::reg_off_t cpu_addr,
   input  wire logic [7:0]         cpu_wr_data,
   output logic [7:0]              cpu_rd_data,
   output text_pkg::vram_wr_t      vram_wr,
   output text_pkg::pal_wr_t       pal_wr,
   output text_pkg::disp_cfg_t     cfg
);

   localparam int AW   = text_pkg::VRAM_ADDR_W;
   localparam int HI_W = AW - 8;   // address bits held in the _HI registers

   text_pkg::vram_addr_t text_base;
   text_pkg::vram_addr_t attr_base;
   logic [7:0]           charset;
   text_pkg::vram_addr_t vaddr;
   text_pkg::color_idx_t pal_idx;
   logic [7:0]           pal_lo;
   logic                 pal_hi;   // next data write is the high byte

   assign cfg = '{text_base: text_base, attr_base: attr_base, charset: charset};

   // vram store goes straight through, pointer steps on the same edge
   assign vram_wr = '{en:   cpu_wr && (cpu_addr == text_pkg::REG_VDATA),
                      addr: vaddr,
                      data: cpu_wr_data};

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         text_base <= '0;
         attr_base <= '0;
         charset   <= '0;
         vaddr     <= '0;
         pal_idx   <= '0;
         pal_lo    <= '0;
         pal_hi    <= 1'b0;
         pal_wr    <= '0;
      end else begin
         pal_wr.en <= 1'b0;
         if (cpu_wr) begin
            case (cpu_addr)
               text_pkg::REG_TEXT_LO:  text_base[7:0]    <= cpu_wr_data;
               text_pkg::REG_TEXT_HI:  text_base[AW-1:8] <= cpu_wr_data[HI_W-1:0];
               text_pkg::REG_ATTR_LO:  attr_base[7:0]    <= cpu_wr_data;
               text_pkg::REG_ATTR_HI:  attr_base[AW-1:8] <= cpu_wr_data[HI_W-1:0];
               text_pkg::REG_CHARSET:  charset           <= cpu_wr_data;
               text_pkg::REG_PAL_IDX: begin
                  pal_idx <= cpu_wr_data[3:0];
                  pal_hi  <= 1'b0;
               end
               text_pkg::REG_PAL_DATA: begin
                  if (!pal_hi) begin
                     pal_lo <= cpu_wr_data;
                     pal_hi <= 1'b1;
                  end else begin
                     pal_wr  <= '{en: 1'b1, idx: pal_idx, color: {cpu_wr_data, pal_lo}};
                     pal_idx <= pal_idx + 1'b1;   // auto increment
                     pal_hi  <= 1'b0;
                  end
               end
               text_pkg::REG_VADDR_LO: vaddr[7:0]    <= cpu_wr_data;
               text_pkg::REG_VADDR_HI: vaddr[AW-1:8] <= cpu_wr_data[HI_W-1:0];
               text_pkg::REG_VDATA:    vaddr         <= vaddr + 1'b1;
               default: ;
            endcase
         end
      end
   end

   // data ports are write only and read as zero
   always_ff @(posedge sys_clk) begin
      if (rst) begin
         cpu_rd_data <= '0;
      end else if (cpu_rd) begin
         case (cpu_addr)
            text_pkg::REG_TEXT_LO:  cpu_rd_data <= text_base[7:0];
            text_pkg::REG_TEXT_HI:  cpu_rd_data <= 8'(text_base[AW-1:8]);
            text_pkg::REG_ATTR_LO:  cpu_rd_data <= attr_base[7:0];
            text_pkg::REG_ATTR_HI:  cpu_rd_data <= 8'(attr_base[AW-1:8]);
            text_pkg::REG_CHARSET:  cpu_rd_data <= charset;
            text_pkg::REG_PAL_IDX:  cpu_rd_data <= 8'(pal_idx);
            text_pkg::REG_VADDR_LO: cpu_rd_data <= vaddr[7:0];
            text_pkg::REG_VADDR_HI: cpu_rd_data <= 8'(vaddr[AW-1:8]);
            default:                cpu_rd_data <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verilog/char_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module char_fetch #(
   parameter int COLS       = 40,
   parameter int FIFO_DEPTH = 4
) (
   input  wire logic                sys_clk,
   input  wire logic                rst,
   input  wire text_pkg::disp_cfg_t cfg,
   input  wire logic                frame_start,
   input  wire logic                line_start,
   output logic                     line_busy,
   output text_pkg::vram_addr_t     vram_addr,
   input  wire logic [7:0]          vram_data,
   output logic                     slice_valid,
   output text_pkg::glyph_slice_t   slice,
   input  wire logic                credit_ret
);

   localparam int COL_W = (COLS > 1) ? $clog2(COLS) : 1;
   localparam int CRD_W = $clog2(FIFO_DEPTH + 1);

   text_pkg::fetch_state_t state;
   logic [COL_W-1:0]       col;
   logic [2:0]             scan_row;
   text_pkg::vram_addr_t   text_row;   // start of the current text row
   text_pkg::vram_addr_t   attr_row;
   text_pkg::char_code_t   code;
   text_pkg::char_code_t   attr;
   logic [CRD_W-1:0]       credits;
   logic [15:0]            font_full;
   logic                   last_col;
   logic                   line_done;

   assign last_col  = (col == COL_W'(COLS - 1));
   assign line_done = slice_valid && last_col;
   assign line_busy = (state != text_pkg::IDLE);

   // charset * 256 + code * 8 + scan row
   assign font_full = {cfg.charset, 8'h00} + {5'b00000, code, scan_row};

   always_comb begin
      case (state)
         text_pkg::TEXT: vram_addr = text_row + text_pkg::vram_addr_t'(col);
         text_pkg::ATTR: vram_addr = attr_row + text_pkg::vram_addr_t'(col);
         default:        vram_addr = font_full[text_pkg::VRAM_ADDR_W-1:0];
      endcase
   end

   // font address is held through SEND so the read byte stays put
   assign slice_valid = (state == text_pkg::SEND) && (credits != '0);
   assign slice       = '{bitmap: vram_data, fg: attr[3:0], bg: attr[7:4]};

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         credits <= CRD_W'(FIFO_DEPTH);
      end else if (credit_ret && !slice_valid) begin
         credits <= credits + 1'b1;
      end else if (!credit_ret && slice_valid) begin
         credits <= credits - 1'b1;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         state <= text_pkg::IDLE;
         col   <= '0;
      end else begin
         case (state)
            text_pkg::IDLE: begin
               if (line_start) begin
                  col   <= '0;
                  state <= text_pkg::TEXT;
               end
            end
            text_pkg::TEXT: state <= text_pkg::ATTR;
            text_pkg::ATTR: state <= text_pkg::FONT;
            text_pkg::FONT: state <= text_pkg::SEND;
            text_pkg::SEND: begin
               if (slice_valid) begin
                  if (last_col) begin
                     state <= text_pkg::IDLE;
                  end else begin
                     col   <= col + 1'b1;
                     state <= text_pkg::TEXT;
                  end
               end
            end
            default: state <= text_pkg::IDLE;
         endcase
      end
   end

   // read data lags the address by one state
   always_ff @(posedge sys_clk) begin
      if (state == text_pkg::ATTR) begin
         code <= vram_data;
      end
      if (state == text_pkg::FONT) begin
         attr <= vram_data;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         scan_row <= '0;
         text_row <= '0;
         attr_row <= '0;
      end else if (frame_start) begin
         scan_row <= '0;
         text_row <= cfg.text_base;
         attr_row <= cfg.attr_base;
      end else if (line_done) begin
         scan_row <= scan_row + 1'b1;
         if (scan_row == 3'd7) begin   // next character row
            text_row <= text_row + text_pkg::vram_addr_t'(COLS);
            attr_row <= attr_row + text_pkg::vram_addr_t'(COLS);
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/glyph_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module glyph_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  wire logic                   sys_clk,
   input  wire logic                   rst,
   input  wire logic                   in_valid,
   input  wire text_pkg::glyph_slice_t in_slice,
   output logic                        credit_ret,
   output logic                        out_valid,
   output text_pkg::glyph_slice_t      out_slice,
   input  wire logic                   out_ready
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   text_pkg::glyph_slice_t mem [FIFO_DEPTH];
   logic [PTR_W-1:0]       wr_ptr;
   logic [PTR_W-1:0]       rd_ptr;
   logic [CNT_W-1:0]       count;
   logic                   pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign out_valid = (count != '0);
   assign out_slice = mem[rd_ptr];
   assign pop       = out_valid && out_ready;

   // no full check, the writer only sends against credits
   always_ff @(posedge sys_clk) begin
      if (in_valid) begin
         mem[wr_ptr] <= in_slice;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         credit_ret <= 1'b0;
      end else begin
         credit_ret <= pop;   // one credit back per entry popped
         if (in_valid) wr_ptr <= next_ptr(wr_ptr);
         if (pop)      rd_ptr <= next_ptr(rd_ptr);
         if (in_valid && !pop)      count <= count + 1'b1;
         else if (!in_valid && pop) count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: verilog/pixel_shifter.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_shifter (
   input  wire logic                   sys_clk,
   input  wire logic                   rst,
   input  wire text_pkg::pal_wr_t      pal_wr,
   input  wire logic                   in_valid,
   input  wire text_pkg::glyph_slice_t in_slice,
   output logic                        in_ready,
   output logic                        pix_valid,
   output text_pkg::rgb_t              pix,
   input  wire logic                   pix_ready
);

   text_pkg::rgb_t         palette [16];
   text_pkg::glyph_slice_t cur;       // bitmap shifts left as pixels leave
   logic [2:0]             bit_cnt;
   logic                   accept;
   logic                   last_px;
   logic                   take;
   text_pkg::color_idx_t   px_idx;

   assign accept   = pix_valid && pix_ready;
   assign last_px  = accept && (bit_cnt == 3'd7);
   assign in_ready = !pix_valid || last_px;
   assign take     = in_valid && in_ready;

   assign px_idx = cur.bitmap[7] ? cur.fg : cur.bg;
   assign pix    = palette[px_idx];

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         for (int i = 0; i < 16; i++) begin
            palette[i] <= '0;
         end
      end else if (pal_wr.en) begin
         palette[pal_wr.idx] <= pal_wr.color;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (take) begin
         cur <= in_slice;
      end else if (accept) begin
         cur.bitmap <= {cur.bitmap[6:0], 1'b0};
      end
   end

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         pix_valid <= 1'b0;
         bit_cnt   <= '0;
      end else if (take) begin
         pix_valid <= 1'b1;
         bit_cnt   <= '0;
      end else if (accept) begin
         if (bit_cnt == 3'd7) pix_valid <= 1'b0;   // slice drained, nothing waiting
         bit_cnt <= bit_cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: verilog/text_display.sv
`timescale 1ns/10ps
`default_nettype none

module text_display #(
   parameter int COLS       = 40,
   parameter int FIFO_DEPTH = 4
) (
   input  wire logic               sys_clk,
   input  wire logic               rst,
   input  wire logic               cpu_wr,
   input  wire logic               cpu_rd,
   input  wire text_pkg::reg_off_t cpu_addr,
   input  wire logic [7:0]         cpu_wr_data,
   output logic [7:0]              cpu_rd_data,
   input  wire logic               frame_start,
   input  wire logic               line_start,
   output logic                    line_busy,
   output logic                    pix_valid,
   output text_pkg::rgb_t          pix,
   input  wire logic               pix_ready
);

   text_pkg::vram_wr_t     vram_wr;
   text_pkg::pal_wr_t      pal_wr;
   text_pkg::disp_cfg_t    cfg;
   text_pkg::vram_addr_t   vram_rd_addr;
   logic [7:0]             vram_rd_data;
   logic                   slice_valid;
   text_pkg::glyph_slice_t slice;
   logic                   credit_ret;
   logic                   fifo_valid;
   text_pkg::glyph_slice_t fifo_slice;
   logic                   fifo_ready;

   cpu_regs regs_i (
      .sys_clk, .rst, .cpu_wr, .cpu_rd, .cpu_addr, .cpu_wr_data, .cpu_rd_data,
      .vram_wr, .pal_wr, .cfg
   );

   video_ram vram_i (
      .sys_clk, .wr(vram_wr), .rd_addr(vram_rd_addr), .rd_data(vram_rd_data)
   );

   char_fetch #(.COLS(COLS), .FIFO_DEPTH(FIFO_DEPTH)) fetch_i (
      .sys_clk, .rst, .cfg, .frame_start, .line_start, .line_busy,
      .vram_addr(vram_rd_addr), .vram_data(vram_rd_data),
      .slice_valid, .slice, .credit_ret
   );

   glyph_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
      .sys_clk, .rst, .in_valid(slice_valid), .in_slice(slice), .credit_ret,
      .out_valid(fifo_valid), .out_slice(fifo_slice), .out_ready(fifo_ready)
   );

   pixel_shifter shift_i (
      .sys_clk, .rst, .pal_wr, .in_valid(fifo_valid), .in_slice(fifo_slice),
      .in_ready(fifo_ready), .pix_valid, .pix, .pix_ready
   );

endmodule

`default_nettype wire

// File: verif/tb_text_display.sv
`timescale 1ns/10ps
`default_nettype none

module tb_text_display;

   localparam int COLS         = 4;
   localparam int FIFO_DEPTH   = 2;      // two slices, so random ready stalls the fetcher
   localparam int LINE_TIMEOUT = 4000;   // cycles
   localparam int N_OPS        = 21;

   typedef struct packed {
      logic               wr;
      text_pkg::reg_off_t off;
      logic [7:0]         data;
      logic [7:0]         exp;   // readback, used by reads only
   } cpu_op_t;

   logic                 sys_clk = 1'b0;
   logic                 rst;
   logic                 cpu_wr;
   logic                 cpu_rd;
   text_pkg::reg_off_t   cpu_addr;
   logic [7:0]           cpu_wr_data;
   logic [7:0]           cpu_rd_data;
   logic                 frame_start;
   logic                 line_start;
   logic                 line_busy;
   logic                 pix_valid;
   text_pkg::rgb_t       pix;
   logic                 pix_ready;

   cpu_op_t              ops [N_OPS];
   integer               seed;
   int                   checks = 0;
   int                   errors = 0;
   int                   err0;

   // reference state, follows the register rules
   logic [7:0]           vmem [4096];
   logic [15:0]          pal [16];
   logic [11:0]          m_vaddr = '0;
   logic [11:0]          m_text_base = '0;
   logic [11:0]          m_attr_base = '0;
   logic [7:0]           m_charset = '0;
   logic [3:0]           m_pal_idx = '0;
   logic [7:0]           m_pal_lo = '0;
   logic                 m_pal_hi = 1'b0;
   logic [11:0]          m_text_row = '0;
   logic [11:0]          m_attr_row = '0;
   logic [2:0]           m_scan = '0;

   text_display #(.COLS(COLS), .FIFO_DEPTH(FIFO_DEPTH)) dut_i (
      .sys_clk, .rst, .cpu_wr, .cpu_rd, .cpu_addr, .cpu_wr_data, .cpu_rd_data,
      .frame_start, .line_start, .line_busy, .pix_valid, .pix, .pix_ready
   );

   always #4 sys_clk = ~sys_clk;

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic cpu_write(input text_pkg::reg_off_t off, input logic [7:0] data);
      @(negedge sys_clk);
      cpu_wr      = 1'b1;
      cpu_addr    = off;
      cpu_wr_data = data;
      @(negedge sys_clk);
      cpu_wr = 1'b0;
      case (off)
         text_pkg::REG_TEXT_LO:  m_text_base[7:0]  = data;
         text_pkg::REG_TEXT_HI:  m_text_base[11:8] = data[3:0];
         text_pkg::REG_ATTR_LO:  m_attr_base[7:0]  = data;
         text_pkg::REG_ATTR_HI:  m_attr_base[11:8] = data[3:0];
         text_pkg::REG_CHARSET:  m_charset = data;
         text_pkg::REG_PAL_IDX: begin
            m_pal_idx = data[3:0];
            m_pal_hi  = 1'b0;
         end
         text_pkg::REG_PAL_DATA: begin
            if (m_pal_hi) begin
               pal[m_pal_idx] = {data, m_pal_lo};   // high byte completes the entry
               m_pal_idx      = m_pal_idx + 4'd1;
            end else begin
               m_pal_lo = data;
            end
            m_pal_hi = !m_pal_hi;
         end
         text_pkg::REG_VADDR_LO: m_vaddr[7:0]  = data;
         text_pkg::REG_VADDR_HI: m_vaddr[11:8] = data[3:0];
         text_pkg::REG_VDATA: begin
            vmem[m_vaddr] = data;
            m_vaddr       = m_vaddr + 12'd1;
         end
         default: ;
      endcase
   endtask

   task automatic cpu_read(input text_pkg::reg_off_t off, input logic [7:0] exp);
      @(negedge sys_clk);
      cpu_rd   = 1'b1;
      cpu_addr = off;
      @(negedge sys_clk);
      cpu_rd = 1'b0;
      check_value($sformatf("cpu_rd_data at offset %0d", off), 32'(cpu_rd_data), 32'(exp));
   endtask

   task automatic pulse_frame_start();
      @(negedge sys_clk);
      frame_start = 1'b1;
      @(negedge sys_clk);
      frame_start = 1'b0;
      m_text_row  = m_text_base;
      m_attr_row  = m_attr_base;
      m_scan      = 3'd0;
   endtask

   // pixel k of the current line, msb of each font row first
   function automatic logic [15:0] expected_pixel(input int k);
      logic [11:0] col_off;
      logic [7:0]  code;
      logic [7:0]  attr;
      logic [7:0]  font;
      logic [11:0] font_addr;
      col_off   = 12'(k / 8);
      code      = vmem[m_text_row + col_off];
      attr      = vmem[m_attr_row + col_off];
      font_addr = 12'(int'(m_charset) * 256 + int'(code) * 8 + int'(m_scan));
      font      = vmem[font_addr];
      return font[7 - (k % 8)] ? pal[attr[3:0]] : pal[attr[7:4]];
   endfunction

   task automatic render_line(input string name, input logic rand_ready);
      int   got;
      int   cycles;
      int   e0;
      logic r;
      e0 = errors;
      @(negedge sys_clk);
      line_start = 1'b1;
      @(negedge sys_clk);
      line_start = 1'b0;
      check_value("line_busy", 32'(line_busy), 32'd1);
      got    = 0;
      cycles = 0;
      while (got < COLS * 8 && cycles < LINE_TIMEOUT) begin
         r         = rand_ready ? 1'($random(seed)) : 1'b1;
         pix_ready = r;
         if (pix_valid && r) begin   // transfer on the coming edge
            check_value("pix", 32'(pix), 32'(expected_pixel(got)));
            got++;
         end
         cycles++;
         @(negedge sys_clk);
      end
      if (got < COLS * 8) begin
         $display("timeout: %s gave only %0d of %0d pixels", name, got, COLS * 8);
         errors++;
      end
      cycles = 0;
      while (line_busy && cycles < LINE_TIMEOUT) begin
         cycles++;
         @(negedge sys_clk);
      end
      if (line_busy) begin
         $display("timeout: line_busy never fell in %s", name);
         errors++;
      end
      check_value("pix_valid", 32'(pix_valid), 32'd0);   // no pixel beyond the line
      $display("%s (scan row %0d): %0d pixels, %0d errors", name, m_scan, got, errors - e0);
      m_scan = m_scan + 3'd1;
      if (m_scan == 3'd0) begin
         m_text_row = m_text_row + 12'(COLS);
         m_attr_row = m_attr_row + 12'(COLS);
      end
   endtask

   initial begin
      seed        = 32'h2b86;
      rst         = 1'b1;
      cpu_wr      = 1'b0;
      cpu_rd      = 1'b0;
      cpu_addr    = '0;
      cpu_wr_data = '0;
      frame_start = 1'b0;
      line_start  = 1'b0;
      pix_ready   = 1'b0;
      ops = '{
         '{1'b1, text_pkg::REG_TEXT_LO,  8'h10, 8'h00},
         '{1'b1, text_pkg::REG_TEXT_HI,  8'h01, 8'h00},
         '{1'b1, text_pkg::REG_ATTR_LO,  8'h90, 8'h00},
         '{1'b1, text_pkg::REG_ATTR_HI,  8'h05, 8'h00},
         '{1'b1, text_pkg::REG_CHARSET,  8'h0a, 8'h00},
         '{1'b1, text_pkg::REG_PAL_IDX,  8'h03, 8'h00},
         '{1'b1, text_pkg::REG_VADDR_LO, 8'h23, 8'h00},
         '{1'b1, text_pkg::REG_VADDR_HI, 8'h01, 8'h00},
         '{1'b1, text_pkg::REG_VDATA,    8'h5a, 8'h00},
         '{1'b1, text_pkg::REG_VDATA,    8'ha5, 8'h00},
         '{1'b1, text_pkg::REG_VDATA,    8'h3c, 8'h00},
         '{1'b0, text_pkg::REG_TEXT_LO,  8'h00, 8'h10},
         '{1'b0, text_pkg::REG_TEXT_HI,  8'h00, 8'h01},
         '{1'b0, text_pkg::REG_ATTR_LO,  8'h00, 8'h90},
         '{1'b0, text_pkg::REG_ATTR_HI,  8'h00, 8'h05},
         '{1'b0, text_pkg::REG_CHARSET,  8'h00, 8'h0a},
         '{1'b0, text_pkg::REG_PAL_IDX,  8'h00, 8'h03},
         '{1'b0, text_pkg::REG_PAL_DATA, 8'h00, 8'h00},
         '{1'b0, text_pkg::REG_VADDR_LO, 8'h00, 8'h26},   // start + 3
         '{1'b0, text_pkg::REG_VADDR_HI, 8'h00, 8'h01},
         '{1'b0, text_pkg::REG_VDATA,    8'h00, 8'h00}
      };
      repeat (10) @(negedge sys_clk);
      rst = 1'b0;

      // whole memory through the data port, pointer wraps back to 0
      cpu_write(text_pkg::REG_VADDR_LO, 8'h00);
      cpu_write(text_pkg::REG_VADDR_HI, 8'h00);
      for (int a = 0; a < 4096; a++) cpu_write(text_pkg::REG_VDATA, 8'($random(seed)));
      cpu_write(text_pkg::REG_PAL_IDX, 8'h00);
      for (int i = 0; i < 32; i++) cpu_write(text_pkg::REG_PAL_DATA, 8'($random(seed)));
      $display("load: 4096 vram bytes and 16 palette entries written");

      err0 = errors;
      for (int i = 0; i < N_OPS; i++) begin
         if (ops[i].wr) cpu_write(ops[i].off, ops[i].data);
         else cpu_read(ops[i].off, ops[i].exp);
      end
      $display("register readback: %0d errors", errors - err0);

      pulse_frame_start();
      render_line("scanline, ready held high", 1'b0);
      pulse_frame_start();
      render_line("scanline, random ready", 1'b1);
      for (int i = 1; i < 8; i++) render_line("row advance, same text row", 1'b1);
      render_line("row advance, next text row", 1'b1);
      pulse_frame_start();
      render_line("frame start, first text row", 1'b1);

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
verilog/text_pkg.sv
verilog/video_ram.sv
verilog/cpu_regs.sv
verilog/char_fetch.sv
verilog/glyph_fifo.sv
verilog/pixel_shifter.sv
verilog/text_display.sv
verif/tb_text_display.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_text_display
FILELIST  = compile.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
